//--- src/rv_params.svh
// width, register count and compressed-enable macros for the decode and execute slice
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and pc width in bits
`define RV_XLEN 32

// architectural integer registers
`define RV_NREGS 32

// default for the compressed extension switch
`define RV_ENABLE_COMPRESSED 1

`endif

//--- src/rv_pkg.sv
// vector typedefs, opcode constants, class/alu/state enums, decode and writeback structs
`include "rv_params.svh"

package rv_pkg;

	// data and pc word
	typedef logic [`RV_XLEN-1:0] word_t;
	// register index
	typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

	// rv32i major opcodes
	localparam logic [6:0] OPC_LOAD     = 7'b0000011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
	localparam logic [6:0] OPC_STORE    = 7'b0100011;
	localparam logic [6:0] OPC_OP       = 7'b0110011;
	localparam logic [6:0] OPC_LUI      = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
	localparam logic [6:0] OPC_JALR     = 7'b1100111;
	localparam logic [6:0] OPC_JAL      = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

	// operation class
	typedef enum logic [2:0] {
		OP_ARITH, OP_SHIFT, OP_BRANCH, OP_LDST, OP_JUMP, OP_CSR, OP_CALL
	} op_type_t;

	// alu, shifter and compare operation
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_LT, ALU_LTU, ALU_XOR, ALU_OR, ALU_AND, ALU_PASS_A,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU
	} alu_op_t;

	// decoder issue FSM
	typedef enum logic {
		DEC_IDLE,
		DEC_ISSUED
	} decode_state_t;

	// decoded instruction handed to execute
	typedef struct packed {
		op_type_t  op_type;
		alu_op_t   op;
		word_t     op_a;
		word_t     op_b;
		// branch offset
		word_t     op_c;
		word_t     pc;
		reg_addr_t rd_addr;
		// writes a nonzero rd
		logic      rd_write;
	} dec_bundle_t;

	// retire report
	typedef struct packed {
		reg_addr_t rd_addr;
		word_t     data;
		logic      write_en;
		logic      is_branch;
		logic      taken;
		word_t     target;
	} wb_t;

endpackage

//--- src/rv_c_expand.sv
// expander from the supported 16-bit compressed forms to 32-bit encodings
`timescale 1ns/1ps

module rv_c_expand (
	input  logic [15:0]   i_instr_c16,
	output rv_pkg::word_t o_instr,
	output logic          o_supported
);
	import rv_pkg::*;

	// addi x0, x0, 0
	localparam word_t NOP = 32'h0000_0013;

	logic [1:0]  quad;
	logic [2:0]  funct3;
	reg_addr_t   rd_full;
	reg_addr_t   rd_p;
	reg_addr_t   rs2_full;
	reg_addr_t   rs2_p;
	logic [11:0] imm6_sx;
	logic [19:0] imm_lui;
	logic [4:0]  shamt;

	// i-type op-imm encoding, also used for immediate shifts
	function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
			input logic [2:0] f3, input reg_addr_t rd);
		return {imm, rs1, f3, rd, OPC_OP_IMM};
	endfunction

	// r-type register op encoding
	function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	assign quad     = i_instr_c16[1:0];
	assign funct3   = i_instr_c16[15:13];
	assign rd_full  = i_instr_c16[11:7];
	assign rs2_full = i_instr_c16[6:2];
	// primed fields reach x8..x15
	assign rd_p     = {2'b01, i_instr_c16[9:7]};
	assign rs2_p    = {2'b01, i_instr_c16[4:2]};
	assign imm6_sx  = {{6{i_instr_c16[12]}}, i_instr_c16[12], i_instr_c16[6:2]};
	assign imm_lui  = {{14{i_instr_c16[12]}}, i_instr_c16[12], i_instr_c16[6:2]};
	assign shamt    = i_instr_c16[6:2];

	always_comb begin
		o_instr     = NOP;
		o_supported = 1'b0;
		case (quad)
			2'b01: begin
				case (funct3)
					// c.addi
					3'b000: begin
						o_instr     = enc_i(imm6_sx, rd_full, 3'b000, rd_full);
						o_supported = 1'b1;
					end
					// c.li adds to x0
					3'b010: begin
						o_instr     = enc_i(imm6_sx, '0, 3'b000, rd_full);
						o_supported = 1'b1;
					end
					// c.lui, rd of 2 is c.addi16sp and not handled
					3'b011: begin
						if (rd_full != 5'd0 && rd_full != 5'd2) begin
							o_instr     = {imm_lui, rd_full, OPC_LUI};
							o_supported = 1'b1;
						end
					end
					3'b100: begin
						case (i_instr_c16[11:10])
							// c.srli, shamt[5] must be clear on rv32
							2'b00: begin
								if (!i_instr_c16[12]) begin
									o_instr     = enc_i({7'b0000000, shamt}, rd_p, 3'b101, rd_p);
									o_supported = 1'b1;
								end
							end
							// c.srai
							2'b01: begin
								if (!i_instr_c16[12]) begin
									o_instr     = enc_i({7'b0100000, shamt}, rd_p, 3'b101, rd_p);
									o_supported = 1'b1;
								end
							end
							// c.andi
							2'b10: begin
								o_instr     = enc_i(imm6_sx, rd_p, 3'b111, rd_p);
								o_supported = 1'b1;
							end
							// register ops on primed regs
							default: begin
								if (!i_instr_c16[12]) begin
									o_supported = 1'b1;
									case (i_instr_c16[6:5])
										2'b00: o_instr = enc_r(7'b0100000, rs2_p, rd_p, 3'b000, rd_p);
										2'b01: o_instr = enc_r(7'b0000000, rs2_p, rd_p, 3'b100, rd_p);
										2'b10: o_instr = enc_r(7'b0000000, rs2_p, rd_p, 3'b110, rd_p);
										default: o_instr = enc_r(7'b0000000, rs2_p, rd_p, 3'b111, rd_p);
									endcase
								end
							end
						endcase
					end
					default: ;
				endcase
			end
			2'b10: begin
				// c.slli
				if (funct3 == 3'b000 && !i_instr_c16[12]) begin
					o_instr     = enc_i({7'b0000000, shamt}, rd_full, 3'b001, rd_full);
					o_supported = 1'b1;
				end
				// c.mv and c.add, zero rs2 means jr/jalr/ebreak
				else if (funct3 == 3'b100 && rs2_full != 5'd0) begin
					o_supported = 1'b1;
					if (i_instr_c16[12]) begin
						o_instr = enc_r(7'b0000000, rs2_full, rd_full, 3'b000, rd_full);
					end else begin
						o_instr = enc_r(7'b0000000, rs2_full, '0, 3'b000, rd_full);
					end
				end
			end
			// quadrant 0 and full-width codes
			default: ;
		endcase
	end

endmodule

//--- src/rv_decode.sv
// decoder with format select, operand build, register-read addressing and issue FSM
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decode #(
	parameter bit ENABLE_COMPRESSED = `RV_ENABLE_COMPRESSED
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                i_fetch_valid,
	input  rv_pkg::word_t       i_instr,
	input  logic                i_instr_c,
	input  rv_pkg::word_t       i_instr_exp,
	input  logic                i_exp_supported,
	input  rv_pkg::word_t       i_pc,
	output rv_pkg::reg_addr_t   o_ra_addr,
	output rv_pkg::reg_addr_t   o_rb_addr,
	input  rv_pkg::word_t       i_ra_data,
	input  rv_pkg::word_t       i_rb_data,
	output logic                o_decode_valid,
	output rv_pkg::dec_bundle_t o_bundle,
	input  logic                i_exec_complete,
	output logic                o_decode_complete
);
	import rv_pkg::*;

	// instruction formats
	localparam logic [2:0] FMT_R = 3'd0;
	localparam logic [2:0] FMT_I = 3'd1;
	localparam logic [2:0] FMT_S = 3'd2;
	localparam logic [2:0] FMT_B = 3'd3;
	localparam logic [2:0] FMT_U = 3'd4;
	localparam logic [2:0] FMT_J = 3'd5;

	logic          use_exp;
	word_t         instr;
	logic [6:0]    opcode;
	logic [2:0]    funct3;
	logic [2:0]    fmt;
	op_type_t      op_type_w;
	alu_op_t       op_w;
	word_t         imm_i;
	word_t         imm_u;
	word_t         imm_b;
	word_t         op_a_w;
	word_t         op_b_w;
	word_t         op_c_w;
	logic          rd_write_w;
	logic          accept;
	decode_state_t state;

	// expanded form only when the extension is built in
	assign use_exp = (ENABLE_COMPRESSED != 0) && i_instr_c;
	assign instr   = use_exp ? i_instr_exp : i_instr;
	assign opcode  = instr[6:0];
	assign funct3  = instr[14:12];

	// rs1/rs2 fields sit at fixed positions
	assign o_ra_addr = instr[19:15];
	assign o_rb_addr = instr[24:20];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

	// format
	always_comb begin
		case (opcode)
			OPC_OP:             fmt = FMT_R;
			OPC_STORE:          fmt = FMT_S;
			OPC_BRANCH:         fmt = FMT_B;
			OPC_LUI, OPC_AUIPC: fmt = FMT_U;
			OPC_JAL:            fmt = FMT_J;
			// op-imm, load, jalr, fence and system
			default:            fmt = FMT_I;
		endcase
	end

	// operation class
	always_comb begin
		case (opcode)
			OPC_OP, OPC_OP_IMM: begin
				op_type_w = (funct3 == 3'b001 || funct3 == 3'b101) ? OP_SHIFT : OP_ARITH;
			end
			OPC_LUI, OPC_AUIPC: op_type_w = OP_ARITH;
			OPC_BRANCH:         op_type_w = OP_BRANCH;
			OPC_JAL, OPC_JALR:  op_type_w = OP_JUMP;
			OPC_SYSTEM:         op_type_w = (funct3 != 3'b000) ? OP_CSR : OP_CALL;
			// loads, stores and fence go with memory ops
			default:            op_type_w = OP_LDST;
		endcase
	end

	// alu operation
	always_comb begin
		op_w = ALU_ADD;
		case (op_type_w)
			OP_ARITH: begin
				if (opcode == OPC_LUI) begin
					op_w = ALU_PASS_A;
				end else if (opcode != OPC_AUIPC) begin
					case (funct3)
						// bit 30 selects sub on register ops only
						3'b000:  op_w = (fmt == FMT_R && instr[30]) ? ALU_SUB : ALU_ADD;
						3'b010:  op_w = ALU_LT;
						3'b011:  op_w = ALU_LTU;
						3'b100:  op_w = ALU_XOR;
						3'b110:  op_w = ALU_OR;
						default: op_w = ALU_AND;
					endcase
				end
			end
			OP_SHIFT: begin
				if (funct3 == 3'b001) begin
					op_w = ALU_SLL;
				end else begin
					op_w = instr[30] ? ALU_SRA : ALU_SRL;
				end
			end
			OP_BRANCH: begin
				case (funct3)
					3'b001:  op_w = ALU_NE;
					3'b100:  op_w = ALU_LT;
					3'b101:  op_w = ALU_GE;
					3'b110:  op_w = ALU_LTU;
					3'b111:  op_w = ALU_GEU;
					default: op_w = ALU_EQ;
				endcase
			end
			default: op_w = ALU_ADD;
		endcase
	end

	// operands
	always_comb begin
		case (fmt)
			FMT_U:   op_a_w = imm_u;
			FMT_J:   op_a_w = '0;
			default: op_a_w = i_ra_data;
		endcase
		case (fmt)
			FMT_R, FMT_S, FMT_B: op_b_w = i_rb_data;
			// shamt zero extended, else sign-extended immediate
			FMT_I:   op_b_w = (op_type_w == OP_SHIFT) ? word_t'(instr[24:20]) : imm_i;
			// lui adds zero, auipc adds the pc
			FMT_U:   op_b_w = (opcode == OPC_LUI) ? '0 : i_pc;
			default: op_b_w = '0;
		endcase
		op_c_w = (fmt == FMT_B) ? imm_b : '0;
	end

	// unsupported compressed codes retire without a write
	assign rd_write_w = (op_type_w == OP_ARITH || op_type_w == OP_SHIFT)
		&& (instr[11:7] != 5'd0) && (!use_exp || i_exp_supported);

	assign accept = (state == DEC_IDLE) && i_fetch_valid;

	// done pulse comes straight from execute
	assign o_decode_complete = i_exec_complete;

	// issue FSM
	always_ff @(posedge clock) begin
		if (reset) begin
			state          <= DEC_IDLE;
			o_decode_valid <= 1'b0;
		end else begin
			case (state)
				DEC_IDLE: begin
					if (i_fetch_valid) begin
						state          <= DEC_ISSUED;
						o_decode_valid <= 1'b1;
					end
				end
				default: begin
					// execute never stalls, so this is one cycle
					if (i_exec_complete) begin
						state          <= DEC_IDLE;
						o_decode_valid <= 1'b0;
					end
				end
			endcase
		end
	end

	// bundle captured on accept
	always_ff @(posedge clock) begin
		if (accept) begin
			o_bundle.op_type  <= op_type_w;
			o_bundle.op       <= op_w;
			o_bundle.op_a     <= op_a_w;
			o_bundle.op_b     <= op_b_w;
			o_bundle.op_c     <= op_c_w;
			o_bundle.pc       <= i_pc;
			o_bundle.rd_addr  <= instr[11:7];
			o_bundle.rd_write <= rd_write_w;
		end
	end

endmodule

//--- src/rv_regfile.sv
// 32-entry register file with two async read ports, one write port and x0 tied to zero
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_regfile (
	input  logic              clock,
	input  logic              reset,
	input  rv_pkg::reg_addr_t i_ra_addr,
	input  rv_pkg::reg_addr_t i_rb_addr,
	output rv_pkg::word_t     o_ra_data,
	output rv_pkg::word_t     o_rb_data,
	input  logic              i_wr_en,
	input  rv_pkg::reg_addr_t i_wr_addr,
	input  rv_pkg::word_t     i_wr_data
);
	import rv_pkg::*;

	word_t regs [`RV_NREGS];

	// x0 is never written, so it stays at its reset value
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en && i_wr_addr != '0) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// combinational reads
	assign o_ra_data = regs[i_ra_addr];
	assign o_rb_data = regs[i_rb_addr];

endmodule

//--- src/rv_exec.sv
// execute stage with alu, shifter, branch compare, register write and writeback report
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_exec (
	input  logic                clock,
	input  logic                reset,
	input  logic                i_decode_valid,
	input  rv_pkg::dec_bundle_t i_bundle,
	output logic                o_exec_complete,
	output logic                o_wr_en,
	output rv_pkg::reg_addr_t   o_wr_addr,
	output rv_pkg::word_t       o_wr_data,
	output logic                o_wb_valid,
	output rv_pkg::wb_t         o_wb
);
	import rv_pkg::*;

	word_t                      sum;
	word_t                      diff;
	word_t                      result;
	word_t                      target;
	logic                       lt_s;
	logic                       lt_u;
	logic                       taken;
	logic                       is_branch;
	logic [$clog2(`RV_XLEN)-1:0] shamt;

	// shared add path also serves lui pass-a with op_b of zero
	assign sum    = i_bundle.op_a + i_bundle.op_b;
	assign diff   = i_bundle.op_a - i_bundle.op_b;
	assign lt_s   = $signed(i_bundle.op_a) < $signed(i_bundle.op_b);
	assign lt_u   = i_bundle.op_a < i_bundle.op_b;
	assign shamt  = i_bundle.op_b[$clog2(`RV_XLEN)-1:0];
	assign target = i_bundle.pc + i_bundle.op_c;

	assign is_branch = (i_bundle.op_type == OP_BRANCH);

	// alu and shifter
	always_comb begin
		case (i_bundle.op)
			ALU_SUB: result = diff;
			ALU_LT:  result = word_t'(lt_s);
			ALU_LTU: result = word_t'(lt_u);
			ALU_XOR: result = i_bundle.op_a ^ i_bundle.op_b;
			ALU_OR:  result = i_bundle.op_a | i_bundle.op_b;
			ALU_AND: result = i_bundle.op_a & i_bundle.op_b;
			ALU_SLL: result = i_bundle.op_a << shamt;
			ALU_SRL: result = i_bundle.op_a >> shamt;
			ALU_SRA: result = word_t'($signed(i_bundle.op_a) >>> shamt);
			default: result = sum;
		endcase
	end

	// branch condition
	always_comb begin
		case (i_bundle.op)
			ALU_EQ:  taken = (i_bundle.op_a == i_bundle.op_b);
			ALU_NE:  taken = (i_bundle.op_a != i_bundle.op_b);
			ALU_LT:  taken = lt_s;
			ALU_GE:  taken = !lt_s;
			ALU_LTU: taken = lt_u;
			ALU_GEU: taken = !lt_u;
			default: taken = 1'b0;
		endcase
	end

	// no stall, complete as soon as the bundle is valid
	assign o_exec_complete = i_decode_valid;

	// rd_write already excludes x0 and non-alu classes
	assign o_wr_en   = i_decode_valid && i_bundle.rd_write;
	assign o_wr_addr = i_bundle.rd_addr;
	assign o_wr_data = result;

	always_ff @(posedge clock) begin
		if (reset) begin
			o_wb_valid <= 1'b0;
		end else begin
			o_wb_valid <= i_decode_valid;
		end
	end

	// report fields are zero when they do not apply
	always_ff @(posedge clock) begin
		if (i_decode_valid) begin
			o_wb.rd_addr   <= i_bundle.rd_write ? i_bundle.rd_addr : '0;
			o_wb.data      <= i_bundle.rd_write ? result : '0;
			o_wb.write_en  <= i_bundle.rd_write;
			o_wb.is_branch <= is_branch;
			o_wb.taken     <= is_branch && taken;
			o_wb.target    <= is_branch ? target : '0;
		end
	end

endmodule

//--- src/rv_decode_exec.sv
// decode and execute slice with expander, decoder, register file and execute stage
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_decode_exec #(
	parameter bit ENABLE_COMPRESSED = `RV_ENABLE_COMPRESSED
) (
	input  logic          clock,
	input  logic          reset,
	input  logic          i_fetch_valid,
	input  rv_pkg::word_t i_instr,
	input  logic          i_instr_c,
	input  rv_pkg::word_t i_pc,
	output logic          o_fetch_done,
	output logic          o_wb_valid,
	output rv_pkg::wb_t   o_wb
);
	import rv_pkg::*;

	word_t       instr_exp;
	logic        exp_supported;
	reg_addr_t   ra_addr;
	reg_addr_t   rb_addr;
	word_t       ra_data;
	word_t       rb_data;
	logic        decode_valid;
	dec_bundle_t bundle;
	logic        exec_complete;
	logic        wr_en;
	reg_addr_t   wr_addr;
	word_t       wr_data;

	// low half carries the compressed code
	rv_c_expand u_c_expand (
		.i_instr_c16 (i_instr[15:0]),
		.o_instr     (instr_exp),
		.o_supported (exp_supported)
	);

	rv_decode #(
		.ENABLE_COMPRESSED (ENABLE_COMPRESSED)
	) u_decode (
		.clock             (clock),
		.reset             (reset),
		.i_fetch_valid     (i_fetch_valid),
		.i_instr           (i_instr),
		.i_instr_c         (i_instr_c),
		.i_instr_exp       (instr_exp),
		.i_exp_supported   (exp_supported),
		.i_pc              (i_pc),
		.o_ra_addr         (ra_addr),
		.o_rb_addr         (rb_addr),
		.i_ra_data         (ra_data),
		.i_rb_data         (rb_data),
		.o_decode_valid    (decode_valid),
		.o_bundle          (bundle),
		.i_exec_complete   (exec_complete),
		.o_decode_complete (o_fetch_done)
	);

	rv_regfile u_regfile (
		.clock     (clock),
		.reset     (reset),
		.i_ra_addr (ra_addr),
		.i_rb_addr (rb_addr),
		.o_ra_data (ra_data),
		.o_rb_data (rb_data),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data)
	);

	rv_exec u_exec (
		.clock           (clock),
		.reset           (reset),
		.i_decode_valid  (decode_valid),
		.i_bundle        (bundle),
		.o_exec_complete (exec_complete),
		.o_wr_en         (wr_en),
		.o_wr_addr       (wr_addr),
		.o_wr_data       (wr_data),
		.o_wb_valid      (o_wb_valid),
		.o_wb            (o_wb)
	);

endmodule

//--- testbench/rv_decode_exec_props.sv
// bound assertions on the fetch handshake, writeback timing and x0 writes
`timescale 1ns/1ps

module rv_decode_exec_props (
	input logic              clock,
	input logic              reset,
	input logic              i_fetch_done,
	input logic              i_wb_valid,
	input logic              i_wr_en,
	input rv_pkg::reg_addr_t i_wr_addr
);

	// assertion failures so far
	int fail_count = 0;

	// done is a single-cycle pulse
	done_one_cycle: assert property (@(posedge clock) disable iff (reset)
		i_fetch_done |=> !i_fetch_done)
		else begin
			$error("fetch done held for more than one cycle");
			fail_count++;
		end

	// report comes one edge after done
	wb_after_done: assert property (@(posedge clock) disable iff (reset)
		i_fetch_done |=> i_wb_valid)
		else begin
			$error("writeback valid missing one edge after fetch done");
			fail_count++;
		end

	// and never without a done before it
	wb_needs_done: assert property (@(posedge clock) disable iff (reset)
		i_wb_valid |-> $past(i_fetch_done))
		else begin
			$error("writeback valid without fetch done one edge earlier");
			fail_count++;
		end

	// x0 stays zero
	no_x0_write: assert property (@(posedge clock) disable iff (reset)
		i_wr_en |-> (i_wr_addr != '0))
		else begin
			$error("register write to x0 requested");
			fail_count++;
		end

	// quiet outputs right after reset
	quiet_after_reset: assert property (@(posedge clock)
		reset |=> (!i_fetch_done && !i_wb_valid))
		else begin
			$error("done or writeback valid high in the cycle after reset");
			fail_count++;
		end

endmodule

bind rv_decode_exec rv_decode_exec_props u_props (
	.clock        (clock),
	.reset        (reset),
	.i_fetch_done (o_fetch_done),
	.i_wb_valid   (o_wb_valid),
	.i_wr_en      (wr_en),
	.i_wr_addr    (wr_addr)
);

//--- testbench/rv_decode_exec_tb.sv
// testbench for the decode and execute slice, file-driven stimulus with writeback checks
`timescale 1ns/1ps

module rv_decode_exec_tb;
	import rv_pkg::*;

	// cycles allowed for each wait
	localparam int DONE_TIMEOUT = 20;
	localparam int WB_TIMEOUT   = 5;
	// bound on lines read from the stimulus file
	localparam int MAX_LINES    = 200;

	logic  clock;
	logic  reset;
	logic  i_fetch_valid;
	word_t i_instr;
	logic  i_instr_c;
	word_t i_pc;
	logic  o_fetch_done;
	logic  o_wb_valid;
	wb_t   o_wb;

	integer fd;
	integer scan_cnt;
	integer skip_cnt;
	integer n_run;
	reg [8*256-1:0] skip_line;

	// stimulus fields and expected report fields of one line
	logic [31:0] f_instr;
	logic [31:0] f_c;
	logic [31:0] f_pc;
	logic [31:0] f_we;
	logic [31:0] f_rd;
	logic [31:0] f_data;
	logic [31:0] f_br;
	logic [31:0] f_tk;
	logic [31:0] f_tgt;

	rv_decode_exec #(
		.ENABLE_COMPRESSED (1'b1)
	) u_dut (
		.clock         (clock),
		.reset         (reset),
		.i_fetch_valid (i_fetch_valid),
		.i_instr       (i_instr),
		.i_instr_c     (i_instr_c),
		.i_pc          (i_pc),
		.o_fetch_done  (o_fetch_done),
		.o_wb_valid    (o_wb_valid),
		.o_wb          (o_wb)
	);

	// 10 ns clock
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// report an error and end the run
	task automatic stop_run(input string detail);
		$display("%s", detail);
		$display("Verification failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// compare one report field
	task automatic check_field(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			stop_run($sformatf("[FAIL] %s at pc %h: expected %h actual %h",
				name, f_pc, expected, actual));
		end
	endtask

	// present one instruction, wait for done, then for the report
	task automatic run_instr();
		int cycles;
		@(posedge clock);
		#1;
		i_fetch_valid = 1'b1;
		i_instr       = f_instr;
		i_instr_c     = f_c[0];
		i_pc          = f_pc;
		// outputs sampled at the falling edge
		cycles = 0;
		@(negedge clock);
		while (!o_fetch_done && cycles < DONE_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!o_fetch_done) begin
			stop_run($sformatf("timed out waiting for o_fetch_done at pc %h", f_pc));
		end
		// release the valid after the edge that ends done
		@(posedge clock);
		#1;
		i_fetch_valid = 1'b0;
		cycles = 0;
		@(negedge clock);
		while (!o_wb_valid && cycles < WB_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!o_wb_valid) begin
			stop_run($sformatf("timed out waiting for o_wb_valid at pc %h", f_pc));
		end
		check_field("o_wb.write_en", f_we, 32'(o_wb.write_en));
		check_field("o_wb.rd_addr", f_rd, 32'(o_wb.rd_addr));
		check_field("o_wb.data", f_data, o_wb.data);
		check_field("o_wb.is_branch", f_br, 32'(o_wb.is_branch));
		check_field("o_wb.taken", f_tk, 32'(o_wb.taken));
		check_field("o_wb.target", f_tgt, o_wb.target);
	endtask

	// a failed bound assertion ends the run
	always @(negedge clock) begin
		assert (u_dut.u_props.fail_count == 0) else begin
			stop_run("a bound assertion on the handshake, writeback timing or x0 failed");
		end
	end

	initial begin
		reset         = 1'b1;
		i_fetch_valid = 1'b0;
		i_instr       = '0;
		i_instr_c     = 1'b0;
		i_pc          = '0;
		n_run         = 0;
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;

		fd = $fopen("testbench/decode_input.txt", "r");
		if (fd == 0) begin
			stop_run("could not open the stimulus file testbench/decode_input.txt");
		end
		scan_cnt = 0;
		for (int ln = 0; ln < MAX_LINES && scan_cnt != -1; ln++) begin
			scan_cnt = $fscanf(fd, "%h %h %h %h %h %h %h %h %h\n",
				f_instr, f_c, f_pc, f_we, f_rd, f_data, f_br, f_tk, f_tgt);
			if (scan_cnt == 9) begin
				run_instr();
				n_run++;
			end else if (scan_cnt == 0) begin
				// drop the rest of a comment line
				skip_cnt = $fgets(skip_line, fd);
				if (skip_cnt == 0) begin
					scan_cnt = -1;
				end
			end else if (scan_cnt != -1) begin
				stop_run("malformed line in the stimulus file");
			end
		end
		$fclose(fd);

		// let the last handshake assertions complete
		repeat (2) @(negedge clock);

		if (n_run == 0) begin
			stop_run("no instructions were read from the stimulus file");
		end else if (u_dut.u_props.fail_count != 0) begin
			stop_run("a bound assertion failed near the end of the run");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

//--- testbench/decode_input.txt
# columns, all hex: instr c_flag pc | expected write_en rd data is_branch taken target
# register setup and arithmetic
00500093 0 00000100 1 01 00000005 0 0 00000000
ffd00113 0 00000104 1 02 fffffffd 0 0 00000000
123451b7 0 00000108 1 03 12345000 0 0 00000000
00208233 0 0000010c 1 04 00000002 0 0 00000000
003202b3 0 00000110 1 05 12345002 0 0 00000000
40208333 0 00000114 1 06 00000008 0 0 00000000
001123b3 0 00000118 1 07 00000001 0 0 00000000
00113433 0 0000011c 1 08 00000000 0 0 00000000
0011c4b3 0 00000120 1 09 12345005 0 0 00000000
0040e533 0 00000124 1 0a 00000007 0 0 00000000
003175b3 0 00000128 1 0b 12345000 0 0 00000000
# shifts by immediate and by register
01f09613 0 0000012c 1 0c 80000000 0 0 00000000
00065693 0 00000130 1 0d 80000000 0 0 00000000
40115713 0 00000134 1 0e fffffffe 0 0 00000000
41f65913 0 00000138 1 12 ffffffff 0 0 00000000
004097b3 0 0000013c 1 0f 00000014 0 0 00000000
00415833 0 00000140 1 10 3fffffff 0 0 00000000
404158b3 0 00000144 1 11 ffffffff 0 0 00000000
# upper immediates
fffff9b7 0 00000148 1 13 fffff000 0 0 00000000
00001a17 0 0000014c 1 14 0000114c 0 0 00000000
# branches, offset 8, taken then not taken
00108463 0 00000150 0 00 00000000 1 1 00000158
00208463 0 00000154 0 00 00000000 1 0 0000015c
00209463 0 00000158 0 00 00000000 1 1 00000160
00109463 0 0000015c 0 00 00000000 1 0 00000164
00114463 0 00000160 0 00 00000000 1 1 00000168
0020c463 0 00000164 0 00 00000000 1 0 0000016c
0020d463 0 00000168 0 00 00000000 1 1 00000170
00115463 0 0000016c 0 00 00000000 1 0 00000174
0020e463 0 00000170 0 00 00000000 1 1 00000178
00116463 0 00000174 0 00 00000000 1 0 0000017c
00117463 0 00000178 0 00 00000000 1 1 00000180
0020f463 0 0000017c 0 00 00000000 1 0 00000184
# compressed, after the 32-bit addi that c.li matches
00700413 0 00000180 1 08 00000007 0 0 00000000
0000441d 1 00000184 1 08 00000007 0 0 00000000
00001479 1 00000186 1 08 00000005 0 0 00000000
000084a2 1 00000188 1 09 00000005 0 0 00000000
00009486 1 0000018a 1 09 0000000a 0 0 00000000
00008d05 1 0000018c 1 0a fffffffd 0 0 00000000
00008505 1 0000018e 1 0a fffffffe 0 0 00000000
00008d61 1 00000190 1 0a 00000004 0 0 00000000
# store, jal, addi to x0, then a read of x0
00112023 0 00000192 0 00 00000000 0 0 00000000
010000ef 0 00000196 0 00 00000000 0 0 00000000
00908013 0 0000019a 0 00 00000000 0 0 00000000
00000ab3 0 0000019e 1 15 00000000 0 0 00000000

//--- sources.f
+incdir+src
src/rv_pkg.sv
src/rv_c_expand.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_exec.sv
src/rv_decode_exec.sv
testbench/rv_decode_exec_props.sv
testbench/rv_decode_exec_tb.sv
